// ==== Makefile ====
# Verilator build and run of the memory server testbench

TOP := mem_server_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/mem_server_properties.sv ====
/*
 * Handshake and reset checks on the ports of the memory server.
 * Bound into every mem_server instance. Each failure is counted in
 * fail_count, which the testbench reads at the end of the run.
 */

`timescale 1ns/1ps

module mem_server_properties #(
  parameter int p_bank_words = mem_server_pkg::default_bank_words
) (
  input logic                                clk,
  input logic                                rst,
  input logic                                req_rdy,
  input logic                                resp_val,
  input logic                                resp_rdy,
  input mem_msg_pkg::mem_op_e                resp_op,
  input logic [mem_msg_pkg::addr_bits-1:0]   resp_addr,
  input logic [mem_msg_pkg::data_bits-1:0]   resp_data,
  input logic [mem_msg_pkg::len_bits-1:0]    resp_len,
  input logic [mem_msg_pkg::opaque_bits-1:0] resp_opaque
);

  int since_rst;
  int fail_count = 0;

  // Cycles since reset release, stops at the clear length
  always_ff @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < p_bank_words) begin
      since_rst <= since_rst + 1;
    end
  end

  // ------------------------------
  // Reset and clear sweep
  // ------------------------------

  quiet_during_clear: assert property (@(posedge clk)
    ((rst && $past(rst)) || (!rst && since_rst < p_bank_words)) |-> (!req_rdy && !resp_val))
    else begin
      fail_count++;
      $error("req_rdy or resp_val high during reset or the clear sweep");
    end

  // ------------------------------
  // Response stall
  // ------------------------------

  // Stalled response keeps every field
  stall_holds_fields: assert property (@(posedge clk) disable iff (rst)
    (resp_val && !resp_rdy) |=> $stable({resp_op, resp_addr, resp_data, resp_len, resp_opaque}))
    else begin
      fail_count++;
      $error("Response fields changed while stalled");
    end

  // No withdraw before the transfer
  val_held_until_taken: assert property (@(posedge clk) disable iff (rst)
    (resp_val && !resp_rdy) |=> resp_val)
    else begin
      fail_count++;
      $error("resp_val dropped without a transfer");
    end

endmodule

bind mem_server mem_server_properties #(
  .p_bank_words (p_bank_words)
) props (
  .clk         (clk),
  .rst         (rst),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_op     (resp_op),
  .resp_addr   (resp_addr),
  .resp_data   (resp_data),
  .resp_len    (resp_len),
  .resp_opaque (resp_opaque)
);

// ==== dv/mem_server_tb.sv ====
/*
 * Testbench of the banked memory server. Runs directed and random traffic,
 * predicts each response from a word model at request acceptance and
 * checks it by tag when it leaves the DUT.
 */

`timescale 1ns/1ps

module mem_server_tb;

  import mem_msg_pkg::*;

  localparam int num_banks  = 4;
  localparam int bank_words = 16;
  localparam int span_words = num_banks * bank_words;
  localparam int num_random = 300;
  // Clear plus about 600 requests at up to ~30 cycles each when stalled
  localparam int cycle_limit = 20000;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   req_val;
  logic                   req_rdy;
  mem_op_e                req_op;
  logic [addr_bits-1:0]   req_addr;
  logic [data_bits-1:0]   req_data;
  logic [len_bits-1:0]    req_len;
  logic [opaque_bits-1:0] req_opaque;
  logic                   resp_val;
  logic                   resp_rdy = 1'b0;
  mem_op_e                resp_op;
  logic [addr_bits-1:0]   resp_addr;
  logic [data_bits-1:0]   resp_data;
  logic [len_bits-1:0]    resp_len;
  logic [opaque_bits-1:0] resp_opaque;

  integer                 seed = 32'h478f;
  bit                     stall_on = 1'b0;
  int                     cycles = 0;
  int                     errors = 0;
  int                     issued = 0;
  int                     received = 0;
  logic [opaque_bits-1:0] next_tag = '0;
  string                  test_name = "";

  // Word model keyed by the aliased word index, absent means zero
  logic [data_bits-1:0]   model [int];

  // Expected responses by tag
  bit                     pending  [256];
  mem_op_e                exp_op   [256];
  logic [addr_bits-1:0]   exp_addr [256];
  logic [data_bits-1:0]   exp_data [256];
  logic [len_bits-1:0]    exp_len  [256];
  string                  exp_test [256];

  mem_server #(
    .p_num_banks  (num_banks),
    .p_bank_words (bank_words)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .req_len     (req_len),
    .req_opaque  (req_opaque),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_op     (resp_op),
    .resp_addr   (resp_addr),
    .resp_data   (resp_data),
    .resp_len    (resp_len),
    .resp_opaque (resp_opaque)
  );

  always #4 clk = ~clk;

  // Consumer side, half the cycles stalled while stall_on is set
  always @(posedge clk) begin
    #1;
    resp_rdy = stall_on ? (($random(seed) & 1) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run timed out with %0d responses outstanding", issued - received);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // Reference model helpers
  // ------------------------------

  // Banks x rows words before the address wraps onto the same rows
  function automatic int word_key(input logic [31:0] addr);
    return int'((addr >> byte_offset_bits) % span_words);
  endfunction

  // Lowest len bytes, 0 is the whole word
  function automatic logic [31:0] len_mask(input logic [1:0] len);
    case (len)
      2'd1:    return 32'h0000_00ff;
      2'd2:    return 32'h0000_ffff;
      2'd3:    return 32'h00ff_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic check_field(input string test, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  // ------------------------------
  // Request driver
  // ------------------------------

  task automatic send_req(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [1:0] len);
    logic [opaque_bits-1:0] tag;
    logic [31:0]            mask;
    logic [31:0]            old;
    int                     key;
    tag = next_tag;
    if (pending[tag]) begin
      errors++;
      $display("Tag %0d is still outstanding and would be reused", tag);
    end
    req_val    = 1'b1;
    req_op     = op;
    req_addr   = addr;
    req_data   = data;
    req_len    = len;
    req_opaque = tag;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    // Accepted here, so model order is acceptance order
    key  = word_key(addr);
    mask = len_mask(len);
    old  = model.exists(key) ? model[key] : '0;
    exp_op[tag]   = op;
    exp_addr[tag] = addr;
    exp_len[tag]  = len;
    exp_test[tag] = test_name;
    if (op == mem_op_write) begin
      model[key]    = (old & ~mask) | (data & mask);
      exp_data[tag] = '0;
    end else begin
      exp_data[tag] = old & mask;
    end
    pending[tag] = 1'b1;
    issued++;
    next_tag = next_tag + 8'd1;
    #1;
    req_val = 1'b0;
  endtask

  // ------------------------------
  // Response monitor
  // ------------------------------

  task automatic check_resp();
    logic [opaque_bits-1:0] tag;
    tag = resp_opaque;
    received++;
    if (!pending[tag]) begin
      errors++;
      $display("Response with tag %0d arrived with no request outstanding", tag);
    end else begin
      check_field(exp_test[tag], "op", 32'(exp_op[tag]), 32'(resp_op));
      check_field(exp_test[tag], "addr", exp_addr[tag], resp_addr);
      check_field(exp_test[tag], "data", exp_data[tag], resp_data);
      check_field(exp_test[tag], "len", 32'(exp_len[tag]), 32'(resp_len));
      pending[tag] = 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (!rst && resp_val && resp_rdy) begin
      check_resp();
    end
  end

  task automatic wait_drain();
    while (received < issued) @(posedge clk);
    #1;
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    logic [31:0] a;
    rst        = 1'b1;
    req_val    = 1'b0;
    req_op     = mem_op_read;
    req_addr   = '0;
    req_data   = '0;
    req_len    = '0;
    req_opaque = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Issued while the clear still runs, accepted right after it
    test_name = "zero_after_clear";
    for (int w = 0; w < span_words; w++) begin
      send_req(mem_op_read, 32'(w * 4), '0, 2'd0);
    end

    test_name = "full_word";
    for (int w = 0; w < span_words; w++) begin
      a = 32'(w * 4);
      send_req(mem_op_write, a, $random(seed), 2'd0);
      send_req(mem_op_read, a, '0, 2'd0);
    end

    // Partial writes merge into the full words above
    test_name = "partial_len";
    for (int n = 1; n < 4; n++) begin
      for (int w = 0; w < 8; w++) begin
        a = 32'(w * 4);
        send_req(mem_op_write, a, $random(seed), 2'(n));
        send_req(mem_op_read, a, '0, 2'(n));
        send_req(mem_op_read, a, '0, 2'd0);
      end
    end

    // High bits above the 256-byte span must not matter
    test_name = "alias";
    for (int w = 0; w < span_words; w += 3) begin
      a = ($random(seed) & 32'hffff_ff00) | 32'(w * 4);
      send_req(mem_op_write, a, $random(seed), 2'd0);
      send_req(mem_op_read, 32'(w * 4), '0, 2'd0);
    end

    test_name = "random_stall";
    stall_on = 1'b1;
    for (int i = 0; i < num_random; i++) begin
      a = $random(seed);
      a[1:0] = 2'b00;
      // Every fourth group of 16 hammers bank 2
      if ((i / 16) % 4 == 3) begin
        a[3:2] = 2'd2;
      end
      send_req((($random(seed) & 1) != 0) ? mem_op_write : mem_op_read,
               a, $random(seed), 2'($random(seed)));
    end
    wait_drain();
    stall_on = 1'b0;

    // Extra cycles catch any duplicate response
    repeat (20) @(posedge clk);
    assert (received == issued) else begin
      errors++;
      $display("MISMATCH response_count expected %0d actual %0d", issued, received);
    end

    $display("Errors: %0d, assertion failures: %0d", errors, uut.props.fail_count);
    if (errors == 0 && uut.props.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/mem_msg_pkg.sv
verilog/mem_server_pkg.sv
verilog/mem_req_router.sv
verilog/mem_bank.sv
verilog/mem_resp_arbiter.sv
verilog/mem_server.sv
dv/mem_server_properties.sv
dv/mem_server_tb.sv

// ==== verilog/mem_bank.sv ====
/*
 * One bank of the memory server. Sweeps zeros over its rows after reset,
 * then serves requests in order with byte-length masking and holds each
 * response in a one-entry register until the arbiter takes it.
 */

`timescale 1ns/1ps

module mem_bank #(
  parameter int p_bank_words = 64
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Request from the router
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  mem_msg_pkg::mem_op_e                  req_op,
  input  logic [$clog2(p_bank_words)-1:0]       req_row,
  input  logic [mem_msg_pkg::addr_bits-1:0]     req_addr,
  input  logic [mem_msg_pkg::data_bits-1:0]     req_data,
  input  logic [mem_msg_pkg::len_bits-1:0]      req_len,
  input  logic [mem_msg_pkg::opaque_bits-1:0]   req_opaque,

  // Response to the arbiter
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output mem_msg_pkg::mem_op_e                  resp_op,
  output logic [mem_msg_pkg::addr_bits-1:0]     resp_addr,
  output logic [mem_msg_pkg::data_bits-1:0]     resp_data,
  output logic [mem_msg_pkg::len_bits-1:0]      resp_len,
  output logic [mem_msg_pkg::opaque_bits-1:0]   resp_opaque
);

  import mem_msg_pkg::*;
  import mem_server_pkg::*;

  localparam int row_bits = $clog2(p_bank_words);

  bank_state_e          state;
  logic [row_bits-1:0]  clear_row;
  logic [data_bits-1:0] mem [p_bank_words];

  logic                 accept;
  logic                 clearing;
  logic [data_bytes-1:0] byte_en;
  logic [data_bits-1:0] rd_word;
  logic [data_bits-1:0] merged;
  logic [data_bits-1:0] masked;
  logic                 mem_we;
  logic [row_bits-1:0]  mem_waddr;
  logic [data_bits-1:0] mem_wdata;

  // ------------------------------
  // Clear sequencer
  // ------------------------------

  // One row per cycle, ready after the last row
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= bank_clear;
      clear_row <= '0;
    end else if (state == bank_clear) begin
      clear_row <= clear_row + 1'b1;
      if (clear_row == row_bits'(p_bank_words - 1)) begin
        state <= bank_ready;
      end
    end
  end

  assign clearing = (state == bank_clear);

  // Taking a new request while the old response leaves is allowed
  assign req_rdy = !clearing && (!resp_val || resp_rdy);
  assign accept  = req_val && req_rdy;

  // ------------------------------
  // Byte lanes
  // ------------------------------

  assign rd_word = mem[req_row];

  // Length 0 means every byte
  always_comb begin
    for (int i = 0; i < data_bytes; i++) begin
      byte_en[i]         = (req_len == '0) || (i < int'(req_len));
      merged[i*8 +: 8]   = byte_en[i] ? req_data[i*8 +: 8] : rd_word[i*8 +: 8];
      masked[i*8 +: 8]   = byte_en[i] ? rd_word[i*8 +: 8] : 8'h00;
    end
  end

  // Single write port shared by the sweep and request writes
  assign mem_we    = clearing || (accept && req_op == mem_op_write);
  assign mem_waddr = clearing ? clear_row : req_row;
  assign mem_wdata = clearing ? '0 : merged;

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= mem_wdata;
    end
  end

  // ------------------------------
  // Response register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val <= 1'b0;
    end else if (accept) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // Echo fields, write acks carry zero data
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_op     <= req_op;
      resp_addr   <= req_addr;
      resp_len    <= req_len;
      resp_opaque <= req_opaque;
      resp_data   <= (req_op == mem_op_read) ? masked : '0;
    end
  end

endmodule

// ==== verilog/mem_msg_pkg.sv ====
/*
 * Field widths and opcodes of the memory request/response port.
 * Modules name these in their port lists with the package scope and
 * import the package inside the body for local declarations.
 */

package mem_msg_pkg;

  // ------------------------------
  // Message field widths
  // ------------------------------

  // Byte address carried by every request and echoed in the response
  localparam int addr_bits = 32;

  // One memory word
  localparam int data_bits = 32;

  // Bytes per word, used for byte lanes in the banks
  localparam int data_bytes = data_bits / 8;

  // Byte length, 0 selects the full word
  localparam int len_bits = 2;

  // Tag returned untouched so out-of-order responses can be matched
  localparam int opaque_bits = 8;

  // Address bits below the word index
  localparam int byte_offset_bits = 2;

  // ------------------------------
  // Opcodes
  // ------------------------------

  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_e;

endpackage

// ==== verilog/mem_req_router.sv ====
/*
 * Request router of the memory server. Splits the word index into a
 * bank select and a row, raises the valid of the addressed bank only and
 * returns that bank's ready to the requester.
 */

`timescale 1ns/1ps

module mem_req_router #(
  parameter int p_num_banks  = 4,
  parameter int p_bank_words = 64
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Request port from outside
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  mem_msg_pkg::mem_op_e                  req_op,
  input  logic [mem_msg_pkg::addr_bits-1:0]     req_addr,
  input  logic [mem_msg_pkg::data_bits-1:0]     req_data,
  input  logic [mem_msg_pkg::len_bits-1:0]      req_len,
  input  logic [mem_msg_pkg::opaque_bits-1:0]   req_opaque,

  // Request side of the banks
  output logic [p_num_banks-1:0]                bank_req_val,
  input  logic [p_num_banks-1:0]                bank_req_rdy,
  output mem_msg_pkg::mem_op_e                  bank_req_op,
  output logic [$clog2(p_bank_words)-1:0]       bank_req_row,
  output logic [mem_msg_pkg::addr_bits-1:0]     bank_req_addr,
  output logic [mem_msg_pkg::data_bits-1:0]     bank_req_data,
  output logic [mem_msg_pkg::len_bits-1:0]      bank_req_len,
  output logic [mem_msg_pkg::opaque_bits-1:0]   bank_req_opaque
);

  import mem_msg_pkg::*;

  localparam int bank_bits = $clog2(p_num_banks);
  localparam int row_bits  = $clog2(p_bank_words);
  localparam int word_bits = addr_bits - byte_offset_bits;

  logic [word_bits-1:0] word_idx;
  logic [bank_bits-1:0] bank_sel;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Low word-index bits pick the bank, the next bits the row
  assign word_idx = req_addr[addr_bits-1:byte_offset_bits];
  assign bank_sel = word_idx[bank_bits-1:0];

  // Upper index bits are dropped so larger addresses alias
  assign bank_req_row = word_idx[bank_bits +: row_bits];

  // Fields fan out to every bank, only the valid is steered
  assign bank_req_op     = req_op;
  assign bank_req_addr   = req_addr;
  assign bank_req_data   = req_data;
  assign bank_req_len    = req_len;
  assign bank_req_opaque = req_opaque;

  // ------------------------------
  // Handshake steering
  // ------------------------------

  // Banks hold their ready low through reset and the clear sweep
  always_comb begin
    bank_req_val = '0;
    bank_req_val[bank_sel] = req_val;
  end

  // Ready follows the addressed bank only
  assign req_rdy = bank_req_rdy[bank_sel];

endmodule

// ==== verilog/mem_resp_arbiter.sv ====
/*
 * Response arbiter of the memory server. Picks one valid bank per cycle
 * in round-robin order and moves its response into the output register,
 * which holds still while the consumer stalls.
 */

`timescale 1ns/1ps

module mem_resp_arbiter #(
  parameter int p_num_banks = 4
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Response side of the banks
  input  logic [p_num_banks-1:0]                bank_resp_val,
  output logic [p_num_banks-1:0]                bank_resp_rdy,
  input  mem_msg_pkg::mem_op_e                  bank_resp_op     [p_num_banks],
  input  logic [mem_msg_pkg::addr_bits-1:0]     bank_resp_addr   [p_num_banks],
  input  logic [mem_msg_pkg::data_bits-1:0]     bank_resp_data   [p_num_banks],
  input  logic [mem_msg_pkg::len_bits-1:0]      bank_resp_len    [p_num_banks],
  input  logic [mem_msg_pkg::opaque_bits-1:0]   bank_resp_opaque [p_num_banks],

  // Output response port
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output mem_msg_pkg::mem_op_e                  resp_op,
  output logic [mem_msg_pkg::addr_bits-1:0]     resp_addr,
  output logic [mem_msg_pkg::data_bits-1:0]     resp_data,
  output logic [mem_msg_pkg::len_bits-1:0]      resp_len,
  output logic [mem_msg_pkg::opaque_bits-1:0]   resp_opaque
);

  import mem_msg_pkg::*;

  localparam int idx_bits = $clog2(p_num_banks);

  logic [idx_bits-1:0] ptr;
  logic [idx_bits-1:0] cand;
  logic [idx_bits-1:0] grant_idx;
  logic                found;
  logic                out_free;
  logic                load;

  // ------------------------------
  // Grant selection
  // ------------------------------

  // Search starts at the pointer, index wraps in idx_bits
  always_comb begin
    cand      = ptr;
    grant_idx = ptr;
    found     = 1'b0;
    for (int i = 0; i < p_num_banks; i++) begin
      cand = ptr + idx_bits'(i);
      if (!found && bank_resp_val[cand]) begin
        found     = 1'b1;
        grant_idx = cand;
      end
    end
  end

  // Free when empty or draining this cycle
  assign out_free = !resp_val || resp_rdy;
  assign load     = out_free && found;

  always_comb begin
    bank_resp_rdy = '0;
    bank_resp_rdy[grant_idx] = load;
  end

  // Next search begins just after the bank served last
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (load) begin
      ptr <= grant_idx + 1'b1;
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_val <= 1'b0;
    end else if (load) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      resp_op     <= bank_resp_op[grant_idx];
      resp_addr   <= bank_resp_addr[grant_idx];
      resp_data   <= bank_resp_data[grant_idx];
      resp_len    <= bank_resp_len[grant_idx];
      resp_opaque <= bank_resp_opaque[grant_idx];
    end
  end

endmodule

// ==== verilog/mem_server.sv ====
/*
 * Top level of the banked memory server. Requests pass the router into
 * one of p_num_banks banks and responses return through the round-robin
 * arbiter. Tags match responses that come back out of request order.
 */

`timescale 1ns/1ps

module mem_server #(
  parameter int p_num_banks  = mem_server_pkg::default_num_banks,
  parameter int p_bank_words = mem_server_pkg::default_bank_words
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Request port
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  mem_msg_pkg::mem_op_e                  req_op,
  input  logic [mem_msg_pkg::addr_bits-1:0]     req_addr,
  input  logic [mem_msg_pkg::data_bits-1:0]     req_data,
  input  logic [mem_msg_pkg::len_bits-1:0]      req_len,
  input  logic [mem_msg_pkg::opaque_bits-1:0]   req_opaque,

  // Response port
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output mem_msg_pkg::mem_op_e                  resp_op,
  output logic [mem_msg_pkg::addr_bits-1:0]     resp_addr,
  output logic [mem_msg_pkg::data_bits-1:0]     resp_data,
  output logic [mem_msg_pkg::len_bits-1:0]      resp_len,
  output logic [mem_msg_pkg::opaque_bits-1:0]   resp_opaque
);

  import mem_msg_pkg::*;

  localparam int row_bits = $clog2(p_bank_words);

  // Router to banks, fields shared by all banks
  logic [p_num_banks-1:0] bank_req_val;
  logic [p_num_banks-1:0] bank_req_rdy;
  mem_op_e                bank_req_op;
  logic [row_bits-1:0]    bank_req_row;
  logic [addr_bits-1:0]   bank_req_addr;
  logic [data_bits-1:0]   bank_req_data;
  logic [len_bits-1:0]    bank_req_len;
  logic [opaque_bits-1:0] bank_req_opaque;

  // Banks to arbiter, one entry per bank
  logic [p_num_banks-1:0] bank_resp_val;
  logic [p_num_banks-1:0] bank_resp_rdy;
  mem_op_e                bank_resp_op     [p_num_banks];
  logic [addr_bits-1:0]   bank_resp_addr   [p_num_banks];
  logic [data_bits-1:0]   bank_resp_data   [p_num_banks];
  logic [len_bits-1:0]    bank_resp_len    [p_num_banks];
  logic [opaque_bits-1:0] bank_resp_opaque [p_num_banks];

  mem_req_router #(
    .p_num_banks  (p_num_banks),
    .p_bank_words (p_bank_words)
  ) router (
    .clk             (clk),
    .rst             (rst),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .req_op          (req_op),
    .req_addr        (req_addr),
    .req_data        (req_data),
    .req_len         (req_len),
    .req_opaque      (req_opaque),
    .bank_req_val    (bank_req_val),
    .bank_req_rdy    (bank_req_rdy),
    .bank_req_op     (bank_req_op),
    .bank_req_row    (bank_req_row),
    .bank_req_addr   (bank_req_addr),
    .bank_req_data   (bank_req_data),
    .bank_req_len    (bank_req_len),
    .bank_req_opaque (bank_req_opaque)
  );

  // All banks clear in parallel after reset
  for (genvar b = 0; b < p_num_banks; b++) begin : g_bank
    mem_bank #(
      .p_bank_words (p_bank_words)
    ) bank (
      .clk         (clk),
      .rst         (rst),
      .req_val     (bank_req_val[b]),
      .req_rdy     (bank_req_rdy[b]),
      .req_op      (bank_req_op),
      .req_row     (bank_req_row),
      .req_addr    (bank_req_addr),
      .req_data    (bank_req_data),
      .req_len     (bank_req_len),
      .req_opaque  (bank_req_opaque),
      .resp_val    (bank_resp_val[b]),
      .resp_rdy    (bank_resp_rdy[b]),
      .resp_op     (bank_resp_op[b]),
      .resp_addr   (bank_resp_addr[b]),
      .resp_data   (bank_resp_data[b]),
      .resp_len    (bank_resp_len[b]),
      .resp_opaque (bank_resp_opaque[b])
    );
  end

  mem_resp_arbiter #(
    .p_num_banks (p_num_banks)
  ) arbiter (
    .clk              (clk),
    .rst              (rst),
    .bank_resp_val    (bank_resp_val),
    .bank_resp_rdy    (bank_resp_rdy),
    .bank_resp_op     (bank_resp_op),
    .bank_resp_addr   (bank_resp_addr),
    .bank_resp_data   (bank_resp_data),
    .bank_resp_len    (bank_resp_len),
    .bank_resp_opaque (bank_resp_opaque),
    .resp_val         (resp_val),
    .resp_rdy         (resp_rdy),
    .resp_op          (resp_op),
    .resp_addr        (resp_addr),
    .resp_data        (resp_data),
    .resp_len         (resp_len),
    .resp_opaque      (resp_opaque)
  );

endmodule

// ==== verilog/mem_server_pkg.sv ====
/*
 * Bank state encoding and default geometry of the banked memory server.
 * The defaults feed the top-level parameters, which pass them down.
 */

package mem_server_pkg;

  // ------------------------------
  // Bank sequencer states
  // ------------------------------

  // Clear sweeps zeros over every row, ready serves requests
  typedef enum logic {
    bank_clear = 1'b0,
    bank_ready = 1'b1
  } bank_state_e;

  // ------------------------------
  // Default geometry
  // ------------------------------

  // Banks interleaved on the low word-index bits, power of two
  localparam int default_num_banks = 4;

  // Rows per bank, power of two
  localparam int default_bank_words = 64;

endpackage
